// ==== common/vec_core_cfg.svh ====
`ifndef VEC_CORE_CFG_SVH
`define VEC_CORE_CFG_SVH

// element and scalar width
`define VC_DATA_WIDTH 32

// lane count
`define VC_LANES 4

// bits per vector register
`define VC_VLEN 512

// element slots held by each lane
`define VC_ELEMS (`VC_VLEN / (`VC_DATA_WIDTH * `VC_LANES))

`define VC_REG_NUM 32

// instruction and scalar queue depth
`define VC_IQ_DEPTH 8

`endif

// ==== common/vec_isa_pkg.sv ====
package vec_isa_pkg;

    // major opcode of the vector extension
    localparam logic [6:0] OP_V = 7'b1010111;

    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } funct3_e;

    // integer ops and OPMVV reductions share some codes
    typedef enum logic [5:0] {
        VADD_VREDSUM   = 6'b000000,
        VREDAND        = 6'b000001,
        VSUB_VREDOR    = 6'b000010,
        VREDXOR        = 6'b000011,
        VMINU_VREDMINU = 6'b000100,
        VMAXU_VREDMAXU = 6'b000110,
        VAND           = 6'b001001,
        VOR            = 6'b001010,
        VXOR           = 6'b001011
    } funct6_e;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1_rs1_imm;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } vinstr_t;

    function automatic logic is_arith(vinstr_t instr);
        return (instr.opcode == OP_V)
            && (instr.funct3 inside {OPIVV, OPIVX, OPIVI})
            && (instr.funct6 inside {VADD_VREDSUM, VSUB_VREDOR, VAND, VOR, VXOR,
                                     VMINU_VREDMINU, VMAXU_VREDMAXU});
    endfunction

    function automatic logic is_reduction(vinstr_t instr);
        return (instr.opcode == OP_V)
            && (instr.funct3 == OPMVV)
            && (instr.funct6 inside {VADD_VREDSUM, VREDAND, VSUB_VREDOR, VREDXOR,
                                     VMINU_VREDMINU, VMAXU_VREDMAXU});
    endfunction

endpackage

// ==== common/vec_core_pkg.sv ====
`include "vec_core_cfg.svh"

package vec_core_pkg;

    typedef logic [`VC_DATA_WIDTH-1:0] elem_t;

    typedef logic [$clog2(`VC_REG_NUM)-1:0] vreg_addr_t;

    // element position inside one lane
    typedef logic [$clog2(`VC_ELEMS)-1:0] slot_t;

    typedef struct packed {
        elem_t rs1;
    } scalar_op_t;

    // one step of a reduction, shared by the lanes and the final fold
    function automatic elem_t red_op(logic [5:0] funct6, elem_t a, elem_t b);
        case (funct6)
            vec_isa_pkg::VADD_VREDSUM:   return a + b;
            vec_isa_pkg::VREDAND:        return a & b;
            vec_isa_pkg::VSUB_VREDOR:    return a | b;
            vec_isa_pkg::VREDXOR:        return a ^ b;
            vec_isa_pkg::VMINU_VREDMINU: return (a < b) ? a : b;
            vec_isa_pkg::VMAXU_VREDMAXU: return (a > b) ? a : b;
            default:                     return a;
        endcase
    endfunction

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk_i,
    input  logic     resetn_i,
    input  logic     push_i,
    input  logic     pop_i,
    input  payload_t data_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // pointer wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // occupancy only moves when exactly one side is active
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module issue_ctrl (
    input  logic                 clk_i,
    input  logic                 resetn_i,
    input  vec_isa_pkg::vinstr_t vinstr_i,
    input  vec_core_pkg::elem_t  rs1_i,
    input  logic                 vreq_i,
    input  logic                 lanes_idle_i,
    output logic                 v_iq_ack_o,
    output logic                 v_iq_full_o,
    output logic                 start_o,
    output vec_isa_pkg::vinstr_t run_instr_o,
    output vec_core_pkg::elem_t  run_scalar_o
);

    vec_isa_pkg::vinstr_t     iq_head;
    vec_core_pkg::scalar_op_t sq_in;
    vec_core_pkg::scalar_op_t sq_head;
    vec_core_pkg::elem_t      imm_ext;
    logic                     iq_full;
    logic                     iq_empty;
    logic                     sq_full;
    logic                     sq_empty;
    logic                     push;
    logic                     pop;

    //////////////////////////////////////////////////////////////////////
    // queues
    //////////////////////////////////////////////////////////////////////

    // both queues move together, a request while full is simply dropped
    assign v_iq_full_o = iq_full || sq_full;
    assign push        = vreq_i && !v_iq_full_o;
    assign pop         = !iq_empty && !sq_empty && lanes_idle_i;
    assign sq_in.rs1   = rs1_i;

    sync_fifo #(
        .payload_t (vec_isa_pkg::vinstr_t),
        .DEPTH     (`VC_IQ_DEPTH)
    ) instr_fifo_inst (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .push_i   (push),
        .pop_i    (pop),
        .data_i   (vinstr_i),
        .data_o   (iq_head),
        .empty_o  (iq_empty),
        .full_o   (iq_full)
    );

    sync_fifo #(
        .payload_t (vec_core_pkg::scalar_op_t),
        .DEPTH     (`VC_IQ_DEPTH)
    ) scalar_fifo_inst (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .push_i   (push),
        .pop_i    (pop),
        .data_i   (sq_in),
        .data_o   (sq_head),
        .empty_o  (sq_empty),
        .full_o   (sq_full)
    );

    //////////////////////////////////////////////////////////////////////
    // issue
    //////////////////////////////////////////////////////////////////////

    // sign-extended imm5
    assign imm_ext = {{(`VC_DATA_WIDTH-5){iq_head.vs1_rs1_imm[4]}}, iq_head.vs1_rs1_imm};

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            v_iq_ack_o   <= 1'b0;
            start_o      <= 1'b0;
            run_instr_o  <= '0;
            run_scalar_o <= '0;
        end else begin
            v_iq_ack_o <= push;
            start_o    <= pop;
            if (pop) begin
                run_instr_o <= iq_head;
                if (vec_isa_pkg::is_arith(iq_head) && iq_head.funct3 == vec_isa_pkg::OPIVI) begin
                    run_scalar_o <= imm_ext;
                end else begin
                    run_scalar_o <= sq_head.rs1;
                end
            end
        end
    end

endmodule

// ==== lane/lane_regfile.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module lane_regfile (
    input  logic                     clk_i,
    input  logic                     resetn_i,
    input  vec_core_pkg::vreg_addr_t rd_a_reg_i,
    input  vec_core_pkg::vreg_addr_t rd_b_reg_i,
    input  vec_core_pkg::vreg_addr_t wr_reg_i,
    input  vec_core_pkg::slot_t      slot_i,
    input  logic                     wr_en_i,
    input  vec_core_pkg::elem_t      wr_data_i,
    output vec_core_pkg::elem_t      rd_a_o,
    output vec_core_pkg::elem_t      rd_b_o
);

    // one slice of every vector register
    vec_core_pkg::elem_t regs [`VC_REG_NUM][`VC_ELEMS];

    // reads are combinational, all ports share the current slot
    assign rd_a_o = regs[rd_a_reg_i][slot_i];
    assign rd_b_o = regs[rd_b_reg_i][slot_i];

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            for (int r = 0; r < `VC_REG_NUM; r++) begin
                for (int s = 0; s < `VC_ELEMS; s++) begin
                    regs[r][s] <= '0;
                end
            end
        end else if (wr_en_i) begin
            regs[wr_reg_i][slot_i] <= wr_data_i;
        end
    end

endmodule

// ==== lane/vector_lane.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module vector_lane (
    input  logic                 clk_i,
    input  logic                 resetn_i,
    input  logic                 start_i,
    input  vec_isa_pkg::vinstr_t instr_i,
    input  vec_core_pkg::elem_t  scalar_i,
    output logic                 idle_o,
    output logic                 part_valid_o,
    output vec_core_pkg::elem_t  part_o,
    output vec_core_pkg::elem_t  vs1_elem0_o
);

    vec_core_pkg::slot_t slot_q;
    logic                busy_q;
    logic                last_slot;
    logic                is_arith_op;
    logic                is_red_op;
    vec_core_pkg::elem_t vs1_data;
    vec_core_pkg::elem_t vs2_data;
    vec_core_pkg::elem_t op_b;
    vec_core_pkg::elem_t alu_res;
    vec_core_pkg::elem_t acc_q;
    vec_core_pkg::elem_t acc_next;
    vec_core_pkg::elem_t vs1_elem0_q;

    assign is_arith_op = vec_isa_pkg::is_arith(instr_i);
    assign is_red_op   = vec_isa_pkg::is_reduction(instr_i);
    assign last_slot   = busy_q && (slot_q == vec_core_pkg::slot_t'(`VC_ELEMS - 1));
    assign idle_o      = !busy_q && !start_i;

    //////////////////////////////////////////////////////////////////////
    // element sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            busy_q <= 1'b0;
            slot_q <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            slot_q <= '0;
        end else if (last_slot) begin
            busy_q <= 1'b0;
            slot_q <= '0;
        end else if (busy_q) begin
            slot_q <= slot_q + 1'b1;
        end
    end

    lane_regfile regfile_inst (
        .clk_i      (clk_i),
        .resetn_i   (resetn_i),
        .rd_a_reg_i (vec_core_pkg::vreg_addr_t'(instr_i.vs1_rs1_imm)),
        .rd_b_reg_i (vec_core_pkg::vreg_addr_t'(instr_i.vs2)),
        .wr_reg_i   (vec_core_pkg::vreg_addr_t'(instr_i.vd)),
        .slot_i     (slot_q),
        .wr_en_i    (busy_q && is_arith_op),
        .wr_data_i  (alu_res),
        .rd_a_o     (vs1_data),
        .rd_b_o     (vs2_data)
    );

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    // vx and vi forms take the issued scalar
    assign op_b = (instr_i.funct3 == vec_isa_pkg::OPIVV) ? vs1_data : scalar_i;

    always_comb begin
        case (instr_i.funct6)
            vec_isa_pkg::VADD_VREDSUM:   alu_res = vs2_data + op_b;
            vec_isa_pkg::VSUB_VREDOR:    alu_res = vs2_data - op_b;
            vec_isa_pkg::VAND:           alu_res = vs2_data & op_b;
            vec_isa_pkg::VOR:            alu_res = vs2_data | op_b;
            vec_isa_pkg::VXOR:           alu_res = vs2_data ^ op_b;
            vec_isa_pkg::VMINU_VREDMINU: alu_res = (vs2_data < op_b) ? vs2_data : op_b;
            vec_isa_pkg::VMAXU_VREDMAXU: alu_res = (vs2_data > op_b) ? vs2_data : op_b;
            default:                     alu_res = vs2_data;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // partial reduction
    //////////////////////////////////////////////////////////////////////

    // first slot seeds the accumulator
    assign acc_next = (slot_q == '0) ? vs2_data
                                     : vec_core_pkg::red_op(instr_i.funct6, acc_q, vs2_data);

    assign part_valid_o = last_slot && is_red_op;
    assign part_o       = acc_next;
    assign vs1_elem0_o  = vs1_elem0_q;

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            acc_q       <= '0;
            vs1_elem0_q <= '0;
        end else if (busy_q) begin
            if (is_red_op) begin
                acc_q <= acc_next;
            end
            // vs1 slot 0 is needed by the final fold after the last slot
            if (slot_q == '0) begin
                vs1_elem0_q <= vs1_data;
            end
        end
    end

endmodule

// ==== hdl/reduction_unit.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module reduction_unit (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic [`VC_LANES-1:0]  part_valid_i,
    input  vec_core_pkg::elem_t   part_i [`VC_LANES],
    input  vec_core_pkg::elem_t   vs1_elem0_i,
    input  vec_isa_pkg::funct6_e  funct6_i,
    output vec_core_pkg::elem_t   rd_o,
    output logic                  rd_wr_en_o
);

    vec_core_pkg::elem_t fold;
    logic                all_valid;

    // lanes finish in lockstep
    assign all_valid = &part_valid_i;

    // vs1 element 0 is the starting value of the fold
    always_comb begin
        fold = vs1_elem0_i;
        for (int l = 0; l < `VC_LANES; l++) begin
            fold = vec_core_pkg::red_op(funct6_i, fold, part_i[l]);
        end
    end

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            rd_o       <= '0;
            rd_wr_en_o <= 1'b0;
        end else begin
            rd_wr_en_o <= all_valid;
            if (all_valid) begin
                rd_o <= fold;
            end
        end
    end

endmodule

// ==== hdl/vector_core.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module vector_core (
    input  logic                 clk_i,
    input  logic                 resetn_i,
    input  vec_isa_pkg::vinstr_t vinstr_i,
    input  vec_core_pkg::elem_t  rs1_i,
    input  logic                 vreq_i,
    output logic                 vready_o,
    output logic                 v_iq_ack_o,
    output logic                 v_iq_full_o,
    output vec_core_pkg::elem_t  rd_o,
    output logic                 rd_wr_en_o
);

    vec_isa_pkg::vinstr_t  run_instr;
    vec_core_pkg::elem_t   run_scalar;
    logic                  start;
    logic                  lane_idle  [`VC_LANES];
    logic [`VC_LANES-1:0]  part_valid;
    vec_core_pkg::elem_t   part       [`VC_LANES];
    vec_core_pkg::elem_t   vs1_elem0  [`VC_LANES];

    // all lanes run in lockstep, lane 0 speaks for them
    assign vready_o = lane_idle[0];

    issue_ctrl issue_ctrl_inst (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .vinstr_i     (vinstr_i),
        .rs1_i        (rs1_i),
        .vreq_i       (vreq_i),
        .lanes_idle_i (lane_idle[0]),
        .v_iq_ack_o   (v_iq_ack_o),
        .v_iq_full_o  (v_iq_full_o),
        .start_o      (start),
        .run_instr_o  (run_instr),
        .run_scalar_o (run_scalar)
    );

    //////////////////////////////////////////////////////////////////////
    // lanes
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < `VC_LANES; l++) begin : g_lane
        vector_lane lane_inst (
            .clk_i        (clk_i),
            .resetn_i     (resetn_i),
            .start_i      (start),
            .instr_i      (run_instr),
            .scalar_i     (run_scalar),
            .idle_o       (lane_idle[l]),
            .part_valid_o (part_valid[l]),
            .part_o       (part[l]),
            .vs1_elem0_o  (vs1_elem0[l])
        );
    end

    reduction_unit reduction_unit_inst (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .part_valid_i (part_valid),
        .part_i       (part),
        .vs1_elem0_i  (vs1_elem0[0]),
        .funct6_i     (vec_isa_pkg::funct6_e'(run_instr.funct6)),
        .rd_o         (rd_o),
        .rd_wr_en_o   (rd_wr_en_o)
    );

endmodule

// ==== bench/vector_core_asserts.sv ====
`timescale 1ns/1ps

module vector_core_asserts (
    input logic clk_i,
    input logic resetn_i,
    input logic vreq_i,
    input logic v_iq_full_i,
    input logic v_iq_ack_i,
    input logic rd_wr_en_i
);

    logic accepted;

    assign accepted = vreq_i && !v_iq_full_i;

    // ack exactly one cycle after each accepted push
    ack_after_push: assert property (@(posedge clk_i) disable iff (!resetn_i)
        accepted |=> v_iq_ack_i)
        else $error("ack missing one cycle after an accepted push");

    ack_only_for_push: assert property (@(posedge clk_i) disable iff (!resetn_i)
        v_iq_ack_i |-> $past(accepted))
        else $error("ack without an accepted push one cycle before");

    // a request while full is dropped
    no_ack_when_full: assert property (@(posedge clk_i) disable iff (!resetn_i)
        (vreq_i && v_iq_full_i) |=> !v_iq_ack_i)
        else $error("ack after a request made while the queue was full");

    single_cycle_result: assert property (@(posedge clk_i) disable iff (!resetn_i)
        rd_wr_en_i |=> !rd_wr_en_i)
        else $error("rd_wr_en_o high on two consecutive cycles");

endmodule

// ==== bench/vector_core_tb.sv ====
`timescale 1ns/1ps
`include "vec_core_cfg.svh"

module vector_core_tb;

    localparam int VEC_LEN     = `VC_ELEMS * `VC_LANES;
    localparam int SEND_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    localparam logic [5:0] ARITH_F6 [7] = '{
        vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::VSUB_VREDOR, vec_isa_pkg::VAND,
        vec_isa_pkg::VOR, vec_isa_pkg::VXOR, vec_isa_pkg::VMINU_VREDMINU,
        vec_isa_pkg::VMAXU_VREDMAXU
    };
    localparam logic [5:0] RED_F6 [6] = '{
        vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::VREDAND, vec_isa_pkg::VSUB_VREDOR,
        vec_isa_pkg::VREDXOR, vec_isa_pkg::VMINU_VREDMINU, vec_isa_pkg::VMAXU_VREDMAXU
    };
    localparam logic [2:0] ARITH_F3 [3] = '{
        vec_isa_pkg::OPIVV, vec_isa_pkg::OPIVX, vec_isa_pkg::OPIVI
    };

    logic                 clk_i;
    logic                 resetn_i;
    vec_isa_pkg::vinstr_t vinstr_i;
    vec_core_pkg::elem_t  rs1_i;
    logic                 vreq_i;
    logic                 vready_o;
    logic                 v_iq_ack_o;
    logic                 v_iq_full_o;
    vec_core_pkg::elem_t  rd_o;
    logic                 rd_wr_en_o;

    // reference register file, indexed by element
    vec_core_pkg::elem_t vreg [`VC_REG_NUM][VEC_LEN];
    vec_core_pkg::elem_t exp_q [$];
    integer              seed;
    int                  err_cnt = 0;
    int                  check_cnt = 0;
    int                  err_base = 0;
    int                  accept_cnt = 0;
    int                  ack_cnt = 0;
    int                  red_cnt = 0;
    int                  rd_cnt = 0;
    int                  blocked_cnt = 0;

    vector_core vector_core_inst (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .vinstr_i    (vinstr_i),
        .rs1_i       (rs1_i),
        .vreq_i      (vreq_i),
        .vready_o    (vready_o),
        .v_iq_ack_o  (v_iq_ack_o),
        .v_iq_full_o (v_iq_full_o),
        .rd_o        (rd_o),
        .rd_wr_en_o  (rd_wr_en_o)
    );

    bind vector_core vector_core_asserts asserts_inst (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .vreq_i      (vreq_i),
        .v_iq_full_i (v_iq_full_o),
        .v_iq_ack_i  (v_iq_ack_o),
        .rd_wr_en_i  (rd_wr_en_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int pick(int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic arith_known(vec_isa_pkg::vinstr_t i);
        logic f6_ok;
        f6_ok = 1'b0;
        for (int k = 0; k < 7; k++) begin
            f6_ok = f6_ok | (i.funct6 == ARITH_F6[k]);
        end
        return (i.opcode == vec_isa_pkg::OP_V) && f6_ok
            && (i.funct3 == ARITH_F3[0] || i.funct3 == ARITH_F3[1] || i.funct3 == ARITH_F3[2]);
    endfunction

    function automatic logic red_known(vec_isa_pkg::vinstr_t i);
        logic f6_ok;
        f6_ok = 1'b0;
        for (int k = 0; k < 6; k++) begin
            f6_ok = f6_ok | (i.funct6 == RED_F6[k]);
        end
        return (i.opcode == vec_isa_pkg::OP_V) && (i.funct3 == vec_isa_pkg::OPMVV) && f6_ok;
    endfunction

    function automatic vec_core_pkg::elem_t alu_ref(logic [5:0] f6, vec_core_pkg::elem_t a,
                                                    vec_core_pkg::elem_t b);
        case (f6)
            vec_isa_pkg::VADD_VREDSUM:   return a + b;
            vec_isa_pkg::VSUB_VREDOR:    return a - b;
            vec_isa_pkg::VAND:           return a & b;
            vec_isa_pkg::VOR:            return a | b;
            vec_isa_pkg::VXOR:           return a ^ b;
            vec_isa_pkg::VMINU_VREDMINU: return (a < b) ? a : b;
            default:                     return (a > b) ? a : b;
        endcase
    endfunction

    function automatic vec_core_pkg::elem_t red_ref(logic [5:0] f6, vec_core_pkg::elem_t a,
                                                    vec_core_pkg::elem_t b);
        case (f6)
            vec_isa_pkg::VADD_VREDSUM:   return a + b;
            vec_isa_pkg::VREDAND:        return a & b;
            vec_isa_pkg::VSUB_VREDOR:    return a | b;
            vec_isa_pkg::VREDXOR:        return a ^ b;
            vec_isa_pkg::VMINU_VREDMINU: return (a < b) ? a : b;
            default:                     return (a > b) ? a : b;
        endcase
    endfunction

    task automatic apply_model(input vec_isa_pkg::vinstr_t i, input vec_core_pkg::elem_t rs1);
        vec_core_pkg::elem_t b;
        vec_core_pkg::elem_t acc;
        if (arith_known(i)) begin
            for (int e = 0; e < VEC_LEN; e++) begin
                if (i.funct3 == vec_isa_pkg::OPIVV) begin
                    b = vreg[i.vs1_rs1_imm][e];
                end else if (i.funct3 == vec_isa_pkg::OPIVI) begin
                    b = {{(`VC_DATA_WIDTH-5){i.vs1_rs1_imm[4]}}, i.vs1_rs1_imm};
                end else begin
                    b = rs1;
                end
                vreg[i.vd][e] = alu_ref(i.funct6, vreg[i.vs2][e], b);
            end
        end else if (red_known(i)) begin
            // vs1 element 0 folded with every vs2 element
            acc = vreg[i.vs1_rs1_imm][0];
            for (int e = 0; e < VEC_LEN; e++) begin
                acc = red_ref(i.funct6, acc, vreg[i.vs2][e]);
            end
            exp_q.push_back(acc);
            red_cnt++;
        end
    endtask

    // accepted requests, acks and results, all seen mid-cycle
    always @(negedge clk_i) begin : monitor
        vec_core_pkg::elem_t expected;
        if (resetn_i) begin
            if (vreq_i && !v_iq_full_o) begin
                apply_model(vinstr_i, rs1_i);
                accept_cnt++;
            end
            if (vreq_i && v_iq_full_o) begin
                blocked_cnt++;
            end
            if (v_iq_ack_o) begin
                ack_cnt++;
            end
            if (rd_wr_en_o) begin
                rd_cnt++;
                if (exp_q.size() == 0) begin
                    $display("rd_wr_en_o pulsed at %0t with no reduction outstanding", $time);
                    err_cnt++;
                end else begin
                    expected = exp_q.pop_front();
                    check_cnt++;
                    if (rd_o !== expected) begin
                        $display("** Error at %0t: rd_o = %h, expected %h", $time, rd_o,
                                 expected);
                        err_cnt++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    function automatic vec_isa_pkg::vinstr_t make_instr(logic [5:0] f6, logic [2:0] f3,
                                                        logic [4:0] vd, logic [4:0] vs2,
                                                        logic [4:0] vs1);
        vec_isa_pkg::vinstr_t i;
        i.funct6      = f6;
        i.vm          = 1'b1;
        i.vs2         = vs2;
        i.vs1_rs1_imm = vs1;
        i.funct3      = f3;
        i.vd          = vd;
        i.opcode      = vec_isa_pkg::OP_V;
        return i;
    endfunction

    task automatic random_instr(output vec_isa_pkg::vinstr_t i, output vec_core_pkg::elem_t op);
        int kind;
        kind = pick(10);
        op   = $random(seed);
        if (kind < 5) begin
            i = make_instr(ARITH_F6[pick(7)], ARITH_F3[pick(3)], 5'(pick(32)), 5'(pick(32)),
                           5'(pick(32)));
        end else if (kind < 8) begin
            i = make_instr(RED_F6[pick(6)], vec_isa_pkg::OPMVV, 5'(pick(32)), 5'(pick(32)),
                           5'(pick(32)));
        end else begin
            i = $random(seed);
            // recognised patterns get a foreign opcode
            if (arith_known(i) || red_known(i)) begin
                i.opcode = 7'b0100011;
            end
        end
    endtask

    // request held until an edge with room in the queue
    task automatic send(input vec_isa_pkg::vinstr_t i, input vec_core_pkg::elem_t rs1);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        vinstr_i = i;
        rs1_i    = rs1;
        vreq_i   = 1'b1;
        while (!taken) begin
            @(negedge clk_i);
            taken = !v_iq_full_o;
            @(posedge clk_i);
            #1;
            waited++;
            if (!taken && waited > SEND_LIMIT) begin
                abort_run("queue stayed full");
            end
        end
        vreq_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        // two idle cycles in a row only happen with an empty queue
        while (exp_q.size() != 0 || quiet < 3) begin
            @(negedge clk_i);
            quiet = vready_o ? quiet + 1 : 0;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("core did not drain");
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic begin_test();
        err_base    = err_cnt;
        accept_cnt  = 0;
        ack_cnt     = 0;
        red_cnt     = 0;
        rd_cnt      = 0;
        blocked_cnt = 0;
    endtask

    task automatic end_test(input string name);
        drain();
        if (rd_cnt != red_cnt) begin
            $display("** Error at %0t: %0d results for %0d reductions", $time, rd_cnt, red_cnt);
            err_cnt++;
        end
        if (ack_cnt != accept_cnt) begin
            $display("** Error at %0t: %0d acks for %0d pushes", $time, ack_cnt, accept_cnt);
            err_cnt++;
        end
        $display("%s: %0d errors", name, err_cnt - err_base);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        vec_isa_pkg::vinstr_t ins;
        vec_core_pkg::elem_t  op;
        logic [4:0]           ra;
        logic [4:0]           rb;
        logic [4:0]           rc;
        int                   n;
        seed     = 32'hdfa9_e22a;
        resetn_i = 1'b0;
        vreq_i   = 1'b0;
        vinstr_i = '0;
        rs1_i    = '0;
        for (int r = 0; r < `VC_REG_NUM; r++) begin
            for (int e = 0; e < VEC_LEN; e++) begin
                vreg[r][e] = '0;
            end
        end
        repeat (5) @(posedge clk_i);
        #1;
        resetn_i = 1'b1;

        begin_test();
        @(negedge clk_i);
        check_cnt++;
        if (vready_o !== 1'b1 || v_iq_full_o !== 1'b0 || v_iq_ack_o !== 1'b0
                || rd_wr_en_o !== 1'b0) begin
            $display("** Error at %0t: after reset vready %b full %b ack %b rd_wr_en %b",
                     $time, vready_o, v_iq_full_o, v_iq_ack_o, rd_wr_en_o);
            err_cnt++;
        end
        @(posedge clk_i);
        #1;
        end_test("reset");

        // splats from v0, then summed
        begin_test();
        for (int k = 0; k < 4; k++) begin
            send(make_instr(vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::OPIVI, 5'd1, 5'd0,
                            5'(pick(32))), '0);
            send(make_instr(vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::OPIVX, 5'd2, 5'd0, 5'd0),
                 $random(seed));
            send(make_instr(vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::OPMVV, 5'd3, 5'd1, 5'd2),
                 '0);
        end
        end_test("immediate and scalar forms");

        begin_test();
        for (int k = 0; k < 14; k++) begin
            ra = 5'(pick(31) + 1);
            rb = 5'(pick(31) + 1);
            rc = 5'(pick(31) + 1);
            send(make_instr(vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::OPIVX, ra, 5'd0, 5'd0),
                 $random(seed));
            send(make_instr(vec_isa_pkg::VADD_VREDSUM, vec_isa_pkg::OPIVX, rb, 5'd0, 5'd0),
                 $random(seed));
            send(make_instr(ARITH_F6[k % 7], vec_isa_pkg::OPIVV, rc, ra, rb), '0);
            send(make_instr(RED_F6[pick(6)], vec_isa_pkg::OPMVV, 5'd0, rc, 5'(pick(32))), '0);
        end
        end_test("vector-vector forms");

        begin_test();
        n = 0;
        while (blocked_cnt == 0 && n < 40) begin
            random_instr(ins, op);
            send(ins, op);
            n++;
        end
        repeat (6) begin
            random_instr(ins, op);
            send(ins, op);
        end
        if (blocked_cnt == 0) begin
            $display("back-pressure: v_iq_full_o never rose under gapless requests");
            err_cnt++;
        end
        end_test("back-pressure");

        begin_test();
        for (int k = 0; k < 200; k++) begin
            random_instr(ins, op);
            send(ins, op);
            repeat (pick(4)) begin
                @(posedge clk_i);
                #1;
            end
        end
        end_test("random stream");

        $display("%0d results checked, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vector_core.f ====
+incdir+common
common/vec_isa_pkg.sv
common/vec_core_pkg.sv
hdl/sync_fifo.sv
hdl/issue_ctrl.sv
lane/lane_regfile.sv
lane/vector_lane.sv
hdl/reduction_unit.sv
hdl/vector_core.sv
bench/vector_core_asserts.sv
bench/vector_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the vector core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f vector_core.f --top-module vector_core_tb -o vector_core_sim

# the simulator status is not trusted, the log decides
./obj_dir/vector_core_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
